// ==== irf_pkg.sv ====
/*
 * Shared widths, thread count and command opcode for the windowed register file.
 * Every module refers to these by scoped name.
 */
package irf_pkg;

	// Number of hardware threads sharing the core
	localparam int num_threads = 4;

	// Number of saved windows each thread may keep in the backing store
	localparam int num_windows = 8;

	// Thread number, wide enough for every thread of the core
	typedef logic [$clog2(num_threads)-1:0] thread_t;

	// Window slot number within one thread's part of the backing store
	typedef logic [$clog2(num_windows)-1:0] window_t;

	// Address into a cell's window store
	// The thread sits in the upper two bits and the window in the lower three,
	// so each thread owns a contiguous block of eight slots
	typedef logic [$bits(thread_t)+$bits(window_t)-1:0] slot_t;

	// Command opcode on the command channel
	// A save copies a whole thread out to a slot, a restore copies it back
	typedef enum logic {
		op_save    = 1'b0,
		op_restore = 1'b1
	} window_op_e;

endpackage

// ==== irf_window_if.sv ====
/*
 * Window save/restore strobes from the window controller to the register array.
 * The controller drives through ctl, the array and every cell listen through array.
 */
interface irf_window_if;

	// One-cycle strobes, never both high together
	logic save;
	logic restore;

	// Thread and window slot that the strobe applies to
	irf_pkg::thread_t thread;
	irf_pkg::window_t window;

	modport ctl (
		output save, restore, thread, window
	);

	modport array (
		input save, restore, thread, window
	);

endinterface

// ==== irf_cell.sv ====
/*
 * One register index of the file across all threads, plus its window store.
 * The array instantiates one cell per register index.
 */
module irf_cell #(
	parameter int data_width = 72
) (
	input  logic                               clk,
	input  logic [irf_pkg::num_threads-1:0]    wr_thread_en,
	input  logic [data_width-1:0]              wr_data,
	irf_window_if.array                        win,
	input  irf_pkg::thread_t                   rd_thread,
	output logic [data_width-1:0]              rd_data
);

	// Every thread and window combination gets its own slot
	localparam int num_slots = 2 ** $bits(irf_pkg::slot_t);

	// Architectural copy of this register for each thread
	logic [data_width-1:0] thread_reg [irf_pkg::num_threads];

	// Backing store holding the saved windows of all threads
	logic [data_width-1:0] store [num_slots];

	irf_pkg::slot_t                  slot;
	logic [data_width-1:0]           restore_data;
	logic [irf_pkg::num_threads-1:0] restore_en;

	// Save and restore share one slot address since they never overlap
	assign slot = {win.thread, win.window};

	// Store read is asynchronous so a restore lands at the same edge
	assign restore_data = store[slot];

	// Only the thread named by the strobe takes restore data
	always_comb begin
		for (int t = 0; t < irf_pkg::num_threads; t++) begin
			restore_en[t] = win.restore && (win.thread == irf_pkg::thread_t'(t));
		end
	end

	// A save captures the register as it stands before this edge
	always_ff @(posedge clk) begin
		if (win.save) begin
			store[slot] <= thread_reg[win.thread];
		end
	end

	// Restore data wins over write data for the restored thread.
	// Writes to the other threads go ahead in the same cycle
	always_ff @(posedge clk) begin
		for (int t = 0; t < irf_pkg::num_threads; t++) begin
			if (restore_en[t]) begin
				thread_reg[t] <= restore_data;
			end else if (wr_thread_en[t]) begin
				thread_reg[t] <= wr_data;
			end
		end
	end

	// Combinational read of the selected thread
	assign rd_data = thread_reg[rd_thread];

endmodule

// ==== irf_array.sv ====
/*
 * Array of register cells, one per register index.
 * Decodes the write port, fans the window strobes out, and muxes the read port.
 */
module irf_array #(
	parameter int data_width = 72,
	parameter int num_regs   = 8
) (
	input  logic                        clk,
	input  logic                        wr_en,
	input  irf_pkg::thread_t            wr_thread,
	input  logic [$clog2(num_regs)-1:0] wr_reg,
	input  logic [data_width-1:0]       wr_data,
	input  irf_pkg::thread_t            rd_thread,
	input  logic [$clog2(num_regs)-1:0] rd_reg,
	output logic [data_width-1:0]       rd_data,
	irf_window_if.array                 win
);

	localparam int reg_width = $clog2(num_regs);

	// One-hot thread select of the write port, zero when no write
	logic [irf_pkg::num_threads-1:0] thread_dec;

	// Read output of each cell for the thread on rd_thread
	logic [data_width-1:0] cell_rd [num_regs];

	always_comb begin
		for (int t = 0; t < irf_pkg::num_threads; t++) begin
			thread_dec[t] = wr_en && (wr_thread == irf_pkg::thread_t'(t));
		end
	end

	// Every cell sees the same window strobes, so a save or restore
	// moves all registers of a thread in one cycle
	for (genvar i = 0; i < num_regs; i++) begin : g_cell
		logic [irf_pkg::num_threads-1:0] cell_en;

		// Only the indexed cell gets the thread enable
		assign cell_en = (wr_reg == reg_width'(i)) ? thread_dec : '0;

		irf_cell #(
			.data_width (data_width)
		) cell_inst (
			.clk          (clk),
			.wr_thread_en (cell_en),
			.wr_data      (wr_data),
			.win          (win),
			.rd_thread    (rd_thread),
			.rd_data      (cell_rd[i])
		);
	end

	// Register index picks the cell
	assign rd_data = cell_rd[rd_reg];

endmodule

// ==== irf_window_ctl.sv ====
/*
 * Window command controller: takes one save/restore command at a time,
 * issues a single strobe cycle to the array, then holds a completion response.
 */
module irf_window_ctl (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cmd_valid,
	input  irf_pkg::window_op_e  cmd_op,
	input  irf_pkg::thread_t     cmd_thread,
	input  irf_pkg::window_t     cmd_window,
	output logic                 cmd_ready,
	output logic                 done_valid,
	input  logic                 done_ready,
	irf_window_if.ctl            win
);

	typedef enum logic [1:0] {
		st_idle,
		st_strobe,
		st_done
	} state_e;

	state_e               state;
	irf_pkg::window_op_e  op_q;
	irf_pkg::thread_t     thread_q;
	irf_pkg::window_t     window_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_idle;
			op_q     <= irf_pkg::op_save;
			thread_q <= '0;
			window_q <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (cmd_valid) begin
						op_q     <= cmd_op;
						thread_q <= cmd_thread;
						window_q <= cmd_window;
						state    <= st_strobe;
					end
				end
				st_strobe: state <= st_done;
				st_done: begin
					if (done_ready) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign cmd_ready   = (state == st_idle);
	assign done_valid  = (state == st_done);
	assign win.save    = (state == st_strobe) && (op_q == irf_pkg::op_save);
	assign win.restore = (state == st_strobe) && (op_q == irf_pkg::op_restore);
	assign win.thread  = thread_q;
	assign win.window  = window_q;

endmodule

// ==== irf_top.sv ====
/*
 * Top level of the windowed register file for a four-thread core.
 * Joins the window controller and the register array to plain ports.
 */
module irf_top #(
	parameter int data_width = 72,
	parameter int num_regs   = 8
) (
	input  logic                        clk,
	input  logic                        rst,

	// Execution write port
	input  logic                        wr_en,
	input  irf_pkg::thread_t            wr_thread,
	input  logic [$clog2(num_regs)-1:0] wr_reg,
	input  logic [data_width-1:0]       wr_data,

	// Execution read port, combinational
	input  irf_pkg::thread_t            rd_thread,
	input  logic [$clog2(num_regs)-1:0] rd_reg,
	output logic [data_width-1:0]       rd_data,

	// Save/restore command channel
	input  logic                        cmd_valid,
	output logic                        cmd_ready,
	input  irf_pkg::window_op_e         cmd_op,
	input  irf_pkg::thread_t            cmd_thread,
	input  irf_pkg::window_t            cmd_window,

	// Completion channel
	output logic                        done_valid,
	input  logic                        done_ready
);

	// Strobes from controller to array
	irf_window_if win_if ();

	irf_window_ctl ctl_inst (
		.clk        (clk),
		.rst        (rst),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_thread (cmd_thread),
		.cmd_window (cmd_window),
		.cmd_ready  (cmd_ready),
		.done_valid (done_valid),
		.done_ready (done_ready),
		.win        (win_if)
	);

	irf_array #(
		.data_width (data_width),
		.num_regs   (num_regs)
	) array_inst (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_thread (wr_thread),
		.wr_reg    (wr_reg),
		.wr_data   (wr_data),
		.rd_thread (rd_thread),
		.rd_reg    (rd_reg),
		.rd_data   (rd_data),
		.win       (win_if)
	);

endmodule

// ==== tb_irf_top.sv ====
/*
 * Table-driven testbench for the windowed register file top level.
 * Runs writes, reads and save/restore commands against a reference model.
 */
module tb_irf_top;

	localparam int data_width = 72;
	localparam int num_regs   = 8;
	localparam int reg_width  = $clog2(num_regs);

	typedef enum logic [1:0] {
		step_write,
		step_read,
		step_cmd,
		step_write_cmd
	} step_kind_e;

	// One table row; write fields double as the side write of a write-with-command
	typedef struct {
		step_kind_e             kind;
		irf_pkg::thread_t       thread;
		logic [reg_width-1:0]   idx;
		irf_pkg::window_t       window;
		irf_pkg::window_op_e    op;
		logic [data_width-1:0]  data;
		int                     hold;
		irf_pkg::thread_t       wthread;
		logic [reg_width-1:0]   widx;
	} step_t;

	logic                        clk;
	logic                        rst;
	logic                        wr_en;
	irf_pkg::thread_t            wr_thread;
	logic [reg_width-1:0]        wr_reg;
	logic [data_width-1:0]       wr_data;
	irf_pkg::thread_t            rd_thread;
	logic [reg_width-1:0]        rd_reg;
	logic [data_width-1:0]       rd_data;
	logic                        cmd_valid;
	logic                        cmd_ready;
	irf_pkg::window_op_e         cmd_op;
	irf_pkg::thread_t            cmd_thread;
	irf_pkg::window_t            cmd_window;
	logic                        done_valid;
	logic                        done_ready;

	step_t steps [$];
	integer seed = 31046;
	int cycle_count = 0;

	// Reference copies of the registers and of every window store
	logic [data_width-1:0] model_reg [irf_pkg::num_threads][num_regs];
	logic [data_width-1:0] model_store [irf_pkg::num_threads][irf_pkg::num_windows][num_regs];

	irf_top #(
		.data_width (data_width),
		.num_regs   (num_regs)
	) irf_top_inst (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en),
		.wr_thread  (wr_thread),
		.wr_reg     (wr_reg),
		.wr_data    (wr_data),
		.rd_thread  (rd_thread),
		.rd_reg     (rd_reg),
		.rd_data    (rd_data),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.cmd_op     (cmd_op),
		.cmd_thread (cmd_thread),
		.cmd_window (cmd_window),
		.done_valid (done_valid),
		.done_ready (done_ready)
	);

	always #10 clk = ~clk;

	// Each step needs well under 8 cycles on average and the margin covers reset
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= steps.size() * 8 + 50) begin
			$display("Timeout: the test table did not finish within %0d cycles", cycle_count);
			$display("TEST FAIL");
			$fatal(1, "simulation stopped after timeout");
		end
	end

	task automatic check_value(input logic [data_width-1:0] actual,
			input logic [data_width-1:0] expected, input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Fills the word 32 bits at a time so every bit is random
	function automatic logic [data_width-1:0] rand_word();
		logic [data_width-1:0] w;
		w = '0;
		for (int i = 0; i < data_width; i += 32) begin
			w = {w[data_width-33:0], 32'($random(seed))};
		end
		return w;
	endfunction

	task automatic add_step(input step_kind_e kind, input int t, input int r, input int w,
			input irf_pkg::window_op_e op, input int hold, input int wt, input int wr);
		step_t s;
		s.kind    = kind;
		s.thread  = irf_pkg::thread_t'(t);
		s.idx     = reg_width'(r);
		s.window  = irf_pkg::window_t'(w);
		s.op      = op;
		s.data    = rand_word();
		s.hold    = hold;
		s.wthread = irf_pkg::thread_t'(wt);
		s.widx    = reg_width'(wr);
		steps.push_back(s);
	endtask

	// Read-check of every register of one thread
	task automatic add_thread_reads(input int t);
		for (int r = 0; r < num_regs; r++) begin
			add_step(step_read, t, r, 0, irf_pkg::op_save, 0, t, r);
		end
	endtask

	task automatic add_thread_writes(input int t);
		for (int r = 0; r < num_regs; r++) begin
			add_step(step_write, t, r, 0, irf_pkg::op_save, 0, t, r);
		end
	endtask

	task automatic write_reg(input step_t s);
		wr_en     = 1'b1;
		wr_thread = s.thread;
		wr_reg    = s.idx;
		wr_data   = s.data;
		@(posedge clk);
		#2;
		wr_en = 1'b0;
		model_reg[s.thread][s.idx] = s.data;
	endtask

	// Read port has no latency, so the check follows the drive by one unit
	task automatic read_check(input step_t s);
		rd_thread = s.thread;
		rd_reg    = s.idx;
		#1;
		check_value(rd_data, model_reg[s.thread][s.idx],
			$sformatf("thread %0d reg %0d read", s.thread, s.idx));
		@(posedge clk);
		#2;
	endtask

	// Save or restore moves all registers of the thread; a side write is
	// dropped only when a restore hits the same thread
	task automatic update_model(input step_t s, input bit with_write);
		for (int r = 0; r < num_regs; r++) begin
			if (s.op == irf_pkg::op_save) begin
				model_store[s.thread][s.window][r] = model_reg[s.thread][r];
			end else begin
				model_reg[s.thread][r] = model_store[s.thread][s.window][r];
			end
		end
		if (with_write && !(s.op == irf_pkg::op_restore && s.wthread == s.thread)) begin
			model_reg[s.wthread][s.widx] = s.data;
		end
	endtask

	task automatic run_command(input step_t s, input bit with_write);
		cmd_valid  = 1'b1;
		cmd_op     = s.op;
		cmd_thread = s.thread;
		cmd_window = s.window;
		while (!cmd_ready) begin
			@(posedge clk);
			#2;
		end
		// The command is accepted on this edge and the strobe cycle follows
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
		if (with_write) begin
			wr_en     = 1'b1;
			wr_thread = s.wthread;
			wr_reg    = s.widx;
			wr_data   = s.data;
		end
		@(posedge clk);
		#2;
		wr_en = 1'b0;
		update_model(s, with_write);
		check_value(data_width'(done_valid), data_width'(1), "done_valid after strobe");
		check_value(data_width'(cmd_ready), data_width'(0), "cmd_ready after strobe");
		// A further command waits on the channel while the response is held back
		// and the command channel must stay blocked until the done transfer
		cmd_valid = 1'b1;
		repeat (s.hold) begin
			@(posedge clk);
			#2;
			check_value(data_width'(done_valid), data_width'(1), "done_valid while held");
			check_value(data_width'(cmd_ready), data_width'(0), "cmd_ready while held");
		end
		done_ready = 1'b1;
		@(posedge clk);
		#2;
		done_ready = 1'b0;
		cmd_valid  = 1'b0;
		check_value(data_width'(done_valid), data_width'(0), "done_valid after transfer");
		check_value(data_width'(cmd_ready), data_width'(1), "cmd_ready after transfer");
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		wr_en      = 1'b0;
		wr_thread  = '0;
		wr_reg     = '0;
		wr_data    = '0;
		rd_thread  = '0;
		rd_reg     = '0;
		cmd_valid  = 1'b0;
		cmd_op     = irf_pkg::op_save;
		cmd_thread = '0;
		cmd_window = '0;
		done_ready = 1'b0;

		// Every register of every thread, then read all back
		for (int t = 0; t < irf_pkg::num_threads; t++) begin
			add_thread_writes(t);
		end
		for (int t = 0; t < irf_pkg::num_threads; t++) begin
			add_thread_reads(t);
		end

		// Same window number in two threads, then a second window for thread 1
		add_step(step_cmd, 1, 0, 3, irf_pkg::op_save, 0, 0, 0);
		add_step(step_cmd, 2, 0, 3, irf_pkg::op_save, 0, 0, 0);
		add_thread_writes(1);
		add_step(step_cmd, 1, 0, 5, irf_pkg::op_save, 0, 0, 0);
		add_thread_writes(1);
		add_step(step_cmd, 1, 0, 3, irf_pkg::op_restore, 0, 0, 0);
		for (int t = 0; t < irf_pkg::num_threads; t++) begin
			add_thread_reads(t);
		end
		add_step(step_cmd, 1, 0, 5, irf_pkg::op_restore, 0, 0, 0);
		add_thread_reads(1);
		add_thread_writes(2);
		add_step(step_cmd, 2, 0, 3, irf_pkg::op_restore, 0, 0, 0);
		add_thread_reads(2);

		// Restore against a write to the same thread, then to another thread
		add_step(step_write_cmd, 1, 0, 3, irf_pkg::op_restore, 0, 1, 2);
		add_thread_reads(1);
		add_step(step_write_cmd, 1, 0, 5, irf_pkg::op_restore, 0, 0, 4);
		add_thread_reads(0);
		add_thread_reads(1);

		// Completion held off for several cycles
		add_step(step_cmd, 3, 0, 7, irf_pkg::op_save, 6, 0, 0);
		add_thread_writes(3);
		add_step(step_cmd, 3, 0, 7, irf_pkg::op_restore, 4, 0, 0);
		add_thread_reads(3);

		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		check_value(data_width'(cmd_ready), data_width'(1), "cmd_ready after reset");
		check_value(data_width'(done_valid), data_width'(0), "done_valid after reset");

		foreach (steps[i]) begin
			case (steps[i].kind)
				step_write:     write_reg(steps[i]);
				step_read:      read_check(steps[i]);
				step_cmd:       run_command(steps[i], 1'b0);
				step_write_cmd: run_command(steps[i], 1'b1);
			endcase
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== sources.f ====
irf_pkg.sv
irf_window_if.sv
irf_cell.sv
irf_array.sv
irf_window_ctl.sv
irf_top.sv
tb_irf_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the register file testbench with Verilator and runs it.
# A failing check ends in $fatal, which gives a non-zero exit status.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_irf_top \
	-f sources.f \
	-o tb_irf_top

./obj_dir/tb_irf_top
